//--- rf_consts.svh
`ifndef RF_CONSTS_SVH
`define RF_CONSTS_SVH

// image geometry, pixels stored row after row
`define IMG_W 28
`define IMG_H 28
`define IMG_PIXELS 784

// each input word carries four pixels with the lowest byte at the lowest address
`define PIX_PER_WORD 4
`define WORDS_PER_IMG 196

// the receptive field reaches WIN_RAD pixels to each side of its centre
`define WIN_RAD 2

// right shift that turns the 25-pixel sum into the receptive-field value
`define RF_SHIFT 5

`endif

//--- rf_pkg.sv
package rf_pkg;

	typedef logic [7:0] pixel_t;
	typedef logic [9:0] pix_addr_t;
	typedef logic [4:0] coord_t;
	typedef logic [31:0] img_word_t;

	// wide enough for 25 pixels at full scale
	typedef logic [12:0] win_sum_t;

	// bit k covers the column at offset k - 2 from the centre
	typedef logic [4:0] lane_mask_t;

	typedef struct packed {
		pix_addr_t centre;
		pix_addr_t base;
		coord_t col;
		lane_mask_t mask;
		logic first;
		logic last;
	} row_req_t;

	typedef struct packed {
		pixel_t [4:0] pix;
		pix_addr_t centre;
		logic first;
		logic last;
	} row_data_t;

	typedef struct packed {
		pix_addr_t centre;
		pixel_t value;
	} rf_result_t;

	typedef enum logic {
		IDLE,
		SCAN
	} scan_state_t;

endpackage

//--- image_buffer.sv
`include "rf_consts.svh"

module image_buffer (
	input logic clk,
	input logic rst,
	input logic i_word_valid,
	input rf_pkg::img_word_t i_word,
	input logic i_req_valid,
	input rf_pkg::row_req_t i_req,
	output logic o_load_done,
	output logic o_row_valid,
	output rf_pkg::row_data_t o_row
);

	rf_pkg::pixel_t mem [`IMG_PIXELS];
	logic [$clog2(`WORDS_PER_IMG)-1:0] word_cnt;
	rf_pkg::pix_addr_t wr_base;
	rf_pkg::pix_addr_t rd_addr [2*`WIN_RAD+1];

	assign wr_base = rf_pkg::pix_addr_t'(word_cnt * `PIX_PER_WORD);

	// lanes outside the image produce wrapped addresses and are masked on read
	always_comb begin
		for (int k = 0; k <= 2 * `WIN_RAD; k++) begin
			rd_addr[k] = rf_pkg::pix_addr_t'(i_req.base + i_req.col + k - `WIN_RAD);
		end
	end

	always_ff @(posedge clk) begin
		if (i_word_valid) begin
			for (int k = 0; k < `PIX_PER_WORD; k++) begin
				mem[wr_base + k] <= i_word[8*k +: 8];
			end
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			word_cnt <= '0;
			o_load_done <= 1'b0;
		end else begin
			o_load_done <= 1'b0;
			if (i_word_valid) begin
				if (word_cnt == `WORDS_PER_IMG - 1) begin
					word_cnt <= '0;
					o_load_done <= 1'b1;
				end else begin
					word_cnt <= word_cnt + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			o_row_valid <= 1'b0;
		end else begin
			o_row_valid <= i_req_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (i_req_valid) begin
			for (int k = 0; k <= 2 * `WIN_RAD; k++) begin
				o_row.pix[k] <= i_req.mask[k] ? mem[rd_addr[k]] : '0;
			end
			o_row.centre <= i_req.centre;
			o_row.first <= i_req.first;
			o_row.last <= i_req.last;
		end
	end

	// words must not arrive while the scanner is reading the frame
	assert property (@(posedge clk) disable iff (rst) !(i_word_valid && i_req_valid))
		else $error("image word written during a row read");

endmodule

//--- window_scanner.sv
`include "rf_consts.svh"

module window_scanner (
	input logic clk,
	input logic rst,
	input logic i_start,
	output logic o_req_valid,
	output rf_pkg::row_req_t o_req,
	output logic o_scan_done
);

	rf_pkg::scan_state_t state;
	rf_pkg::coord_t cen_row;
	rf_pkg::coord_t cen_col;
	logic [2:0] row_off;
	int src_row;
	int src_col;
	logic row_in;
	logic last_centre;

	assign last_centre = (cen_row == `IMG_H - 1) && (cen_col == `IMG_W - 1);

	// five row reads per centre, centres in raster order
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= rf_pkg::IDLE;
			cen_row <= '0;
			cen_col <= '0;
			row_off <= '0;
		end else begin
			case (state)
				rf_pkg::IDLE: begin
					if (i_start) begin
						state <= rf_pkg::SCAN;
					end
				end
				rf_pkg::SCAN: begin
					if (row_off == 3'(2 * `WIN_RAD)) begin
						row_off <= '0;
						if (cen_col == `IMG_W - 1) begin
							cen_col <= '0;
							if (cen_row == `IMG_H - 1) begin
								cen_row <= '0;
								state <= rf_pkg::IDLE;
							end else begin
								cen_row <= cen_row + 1'b1;
							end
						end else begin
							cen_col <= cen_col + 1'b1;
						end
					end else begin
						row_off <= row_off + 1'b1;
					end
				end
				default: begin
					state <= rf_pkg::IDLE;
				end
			endcase
		end
	end

	always_comb begin
		src_row = int'(cen_row) + int'(row_off) - `WIN_RAD;
		row_in = (src_row >= 0) && (src_row < `IMG_H);
		o_req.centre = rf_pkg::pix_addr_t'(cen_row * `IMG_W + cen_col);
		o_req.base = row_in ? rf_pkg::pix_addr_t'(src_row * `IMG_W) : '0;
		o_req.col = cen_col;
		src_col = 0;
		// a lane is live only when both its row and its column fall inside the image
		for (int k = 0; k <= 2 * `WIN_RAD; k++) begin
			src_col = int'(cen_col) + k - `WIN_RAD;
			o_req.mask[k] = row_in && (src_col >= 0) && (src_col < `IMG_W);
		end
		o_req.first = (row_off == '0);
		o_req.last = (row_off == 3'(2 * `WIN_RAD));
	end

	assign o_req_valid = (state == rf_pkg::SCAN);
	assign o_scan_done = o_req_valid && o_req.last && last_centre;

	// requests only start after a start strobe and open with the top row of pixel 0
	assert property (@(posedge clk) disable iff (rst)
		$rose(o_req_valid) |-> $past(i_start) && o_req.first && (o_req.centre == '0))
		else $error("row request issued outside a started scan");

endmodule

//--- window_accum.sv
`include "rf_consts.svh"

module window_accum (
	input logic clk,
	input logic rst,
	input logic i_row_valid,
	input rf_pkg::row_data_t i_row,
	output logic o_rf_valid,
	output rf_pkg::rf_result_t o_rf
);

	rf_pkg::win_sum_t row_sum;
	rf_pkg::win_sum_t win_sum;
	rf_pkg::win_sum_t acc;

	always_comb begin
		row_sum = '0;
		for (int k = 0; k <= 2 * `WIN_RAD; k++) begin
			row_sum = row_sum + rf_pkg::win_sum_t'(i_row.pix[k]);
		end
		// the first row of a window drops whatever the previous window left behind
		win_sum = i_row.first ? row_sum : acc + row_sum;
	end

	always_ff @(posedge clk) begin
		if (i_row_valid) begin
			acc <= win_sum;
			if (i_row.last) begin
				o_rf.centre <= i_row.centre;
				o_rf.value <= rf_pkg::pixel_t'(win_sum >> `RF_SHIFT);
			end
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			o_rf_valid <= 1'b0;
		end else begin
			o_rf_valid <= i_row_valid && i_row.last;
		end
	end

	// every window takes five row reads so results never come back to back
	assert property (@(posedge clk) disable iff (rst) o_rf_valid |=> !o_rf_valid)
		else $error("results on consecutive cycles");

endmodule

//--- rf_preproc_top.sv
module rf_preproc_top (
	input logic clk,
	input logic rst,
	input logic i_word_valid,
	input rf_pkg::img_word_t i_word,
	input logic i_start,
	output logic o_load_done,
	output logic o_rf_valid,
	output rf_pkg::rf_result_t o_rf,
	output logic o_scan_done
);

	logic req_valid;
	rf_pkg::row_req_t req;
	logic row_valid;
	rf_pkg::row_data_t row;

	window_scanner u_scanner (
		.clk(clk),
		.rst(rst),
		.i_start(i_start),
		.o_req_valid(req_valid),
		.o_req(req),
		.o_scan_done(o_scan_done)
	);

	image_buffer u_buffer (
		.clk(clk),
		.rst(rst),
		.i_word_valid(i_word_valid),
		.i_word(i_word),
		.i_req_valid(req_valid),
		.i_req(req),
		.o_load_done(o_load_done),
		.o_row_valid(row_valid),
		.o_row(row)
	);

	window_accum u_accum (
		.clk(clk),
		.rst(rst),
		.i_row_valid(row_valid),
		.i_row(row),
		.o_rf_valid(o_rf_valid),
		.o_rf(o_rf)
	);

endmodule

//--- tb_rf_model.svh
`ifndef TB_RF_MODEL_SVH
`define TB_RF_MODEL_SVH

// testbench copy of the frame, rewritten before each load and used to predict every result
rf_pkg::pixel_t img [`IMG_PIXELS];
logic [31:0] rng_state = 32'h07f2bc16;
int checks = 0;
int errors = 0;

// xorshift32, one step per call
function automatic logic [31:0] next_rand();
	logic [31:0] x;
	x = rng_state;
	x = x ^ (x << 13);
	x = x ^ (x >> 17);
	x = x ^ (x << 5);
	rng_state = x;
	return x;
endfunction

function automatic void fill_const(input rf_pkg::pixel_t v);
	for (int i = 0; i < `IMG_PIXELS; i++) begin
		img[i] = v;
	end
endfunction

function automatic void fill_random();
	for (int i = 0; i < `IMG_PIXELS; i++) begin
		img[i] = rf_pkg::pixel_t'(next_rand() >> 11);
	end
endfunction

// lowest byte of the word holds the lowest pixel address
function automatic rf_pkg::img_word_t pack_word(input int w);
	rf_pkg::img_word_t word;
	for (int k = 0; k < `PIX_PER_WORD; k++) begin
		word[8*k +: 8] = img[w * `PIX_PER_WORD + k];
	end
	return word;
endfunction

function automatic rf_pkg::rf_result_t model_result(input int idx);
	rf_pkg::rf_result_t res;
	int row;
	int col;
	int r;
	int c;
	int sum;
	row = idx / `IMG_W;
	col = idx % `IMG_W;
	sum = 0;
	for (int dr = -`WIN_RAD; dr <= `WIN_RAD; dr++) begin
		for (int dc = -`WIN_RAD; dc <= `WIN_RAD; dc++) begin
			r = row + dr;
			c = col + dc;
			// pixels beyond the border are padding and add nothing
			if (r >= 0 && r < `IMG_H && c >= 0 && c < `IMG_W) begin
				sum += int'(img[r * `IMG_W + c]);
			end
		end
	end
	res.centre = rf_pkg::pix_addr_t'(idx);
	res.value = rf_pkg::pixel_t'(sum >> `RF_SHIFT);
	return res;
endfunction

task automatic check_result(input string name, input rf_pkg::rf_result_t exp,
		input rf_pkg::rf_result_t act);
	checks++;
	if (act !== exp) begin
		errors++;
		$display("[FAIL] %s: expected %h (centre %h value %h), got %h (centre %h value %h)",
			name, exp, exp.centre, exp.value, act, act.centre, act.value);
	end
endtask

task automatic check_count(input string name, input int exp, input int act);
	checks++;
	if (act != exp) begin
		errors++;
		$display("[FAIL] %s: expected %h, got %h", name, exp, act);
	end
endtask

`endif

//--- tb_rf_preproc.sv
`include "rf_consts.svh"

module tb_rf_preproc;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int SCAN_CYCLES = `IMG_PIXELS * (2 * `WIN_RAD + 1);
	// budget of one load and one scan plus slack for each test
	localparam int TEST_CYCLES = `WORDS_PER_IMG + SCAN_CYCLES + 50;
	localparam int NUM_TESTS = 5;
	localparam int CLK_PERIOD = 10;

	logic clk = 1'b0;
	logic rst;
	logic i_word_valid;
	rf_pkg::img_word_t i_word;
	logic i_start;
	logic o_load_done;
	logic o_rf_valid;
	rf_pkg::rf_result_t o_rf;
	logic o_scan_done;

	// results of the most recent scan in arrival order
	rf_pkg::rf_result_t got [$];

	`include "tb_rf_model.svh"

	rf_preproc_top DUT (
		.clk(clk),
		.rst(rst),
		.i_word_valid(i_word_valid),
		.i_word(i_word),
		.i_start(i_start),
		.o_load_done(o_load_done),
		.o_rf_valid(o_rf_valid),
		.o_rf(o_rf),
		.o_scan_done(o_scan_done)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	initial begin
		#(NUM_TESTS * TEST_CYCLES * CLK_PERIOD);
		$display("timeout: the tests did not finish within %0d ns",
			NUM_TESTS * TEST_CYCLES * CLK_PERIOD);
		$display("Finished with errors");
		$finish;
	end

	// loads the model image with up to max_gap idle cycles before each word
	task automatic load_image(input int max_gap);
		int gap;
		int pulses;
		logic after_last;
		pulses = 0;
		for (int w = 0; w < `WORDS_PER_IMG; w++) begin
			gap = (max_gap == 0) ? 0 : int'(next_rand() % (max_gap + 1));
			repeat (gap) begin
				@(negedge clk);
				pulses += int'(o_load_done);
				i_word_valid = 1'b0;
			end
			@(negedge clk);
			pulses += int'(o_load_done);
			i_word_valid = 1'b1;
			i_word = pack_word(w);
		end
		@(negedge clk);
		after_last = o_load_done;
		i_word_valid = 1'b0;
		i_word = '0;
		repeat (3) begin
			@(negedge clk);
			pulses += int'(o_load_done);
		end
		check_count("o_load_done on the cycle after the last word", 1, int'(after_last));
		check_count("o_load_done pulses elsewhere", 0, pulses);
	endtask

	// starts a scan and checks every result while a nonzero extra_start_at repeats i_start
	task automatic run_scan(input int extra_start_at);
		int cycles;
		int last_cycle;
		int done_cycle;
		int done_cnt;
		int extra;
		got.delete();
		cycles = 0;
		last_cycle = 0;
		done_cycle = 0;
		done_cnt = 0;
		extra = 0;
		@(negedge clk);
		i_start = 1'b1;
		while (got.size() < `IMG_PIXELS && cycles < SCAN_CYCLES + 50) begin
			@(negedge clk);
			cycles++;
			i_start = (cycles == extra_start_at);
			if (o_scan_done) begin
				done_cnt++;
				done_cycle = cycles;
			end
			if (o_rf_valid) begin
				if (got.size() == 0) begin
					check_count("cycles from i_start to first o_rf_valid", 7, cycles);
				end else begin
					check_count("cycles between o_rf_valid", 2 * `WIN_RAD + 1,
						cycles - last_cycle);
				end
				check_result("o_rf", model_result(got.size()), o_rf);
				got.push_back(o_rf);
				last_cycle = cycles;
			end
		end
		i_start = 1'b0;
		if (got.size() < `IMG_PIXELS) begin
			errors++;
			$display("scan stopped after %0d of %0d results", got.size(), `IMG_PIXELS);
		end
		// the pipeline has drained, so nothing else may appear
		repeat (20) begin
			@(negedge clk);
			extra += int'(o_rf_valid);
			done_cnt += int'(o_scan_done);
		end
		check_count("o_scan_done pulses", 1, done_cnt);
		check_count("cycles from o_scan_done to last o_rf_valid", 2, last_cycle - done_cycle);
		check_count("o_rf_valid after the last result", 0, extra);
	endtask

	task automatic test_reset();
		int strobes;
		strobes = 0;
		rst = 1'b1;
		repeat (5) begin
			@(negedge clk);
			strobes += int'(o_load_done) + int'(o_rf_valid) + int'(o_scan_done);
		end
		rst = 1'b0;
		repeat (5) begin
			@(negedge clk);
			strobes += int'(o_load_done) + int'(o_rf_valid) + int'(o_scan_done);
		end
		check_count("o_load_done + o_rf_valid + o_scan_done around reset", 0, strobes);
	endtask

	task automatic test_load_gaps();
		$display("test: loading with idle gaps");
		fill_random();
		load_image(3);
	endtask

	task automatic test_const_image();
		rf_pkg::rf_result_t corner;
		rf_pkg::rf_result_t inner;
		$display("test: constant image");
		corner.centre = '0;
		corner.value = 8'd28;
		inner.centre = rf_pkg::pix_addr_t'(2 * `IMG_W + 2);
		inner.value = 8'd78;
		fill_const(8'd100);
		load_image(0);
		run_scan(0);
		// the corner window holds 9 image pixels and an interior one holds all 25
		if (got.size() == `IMG_PIXELS) begin
			check_result("o_rf at the corner", corner, got[0]);
			check_result("o_rf in the interior", inner, got[2 * `IMG_W + 2]);
		end
	endtask

	task automatic test_random_image();
		$display("test: random image");
		fill_random();
		load_image(0);
		run_scan(0);
	endtask

	task automatic test_reload_rescan();
		$display("test: reload and rescan with a repeated start");
		fill_random();
		load_image(1);
		run_scan(SCAN_CYCLES / 4);
	endtask

	initial begin
		rst = 1'b1;
		i_word_valid = 1'b0;
		i_word = '0;
		i_start = 1'b0;
		test_reset();
		test_load_gaps();
		test_const_image();
		test_random_image();
		test_reload_rescan();
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

//--- vlog.f
+incdir+.
rf_pkg.sv
image_buffer.sv
window_scanner.sv
window_accum.sv
rf_preproc_top.sv
tb_rf_preproc.sv
